// ==== hw/cpuVramPort.sv ====
// CPU VRAM address, modulo and data registers with auto-increment and prefetch sequencer
module cpuVramPort (
	input  logic                CLK_24M,
	input  logic                T73A_OUT,
	// Host side
	input  lspcPkg::regSel_t    cpuSel,
	input  lspcPkg::vramWord_t  cpuWriteData,
	input  logic                cpuWrite,
	output lspcPkg::vramWord_t  cpuReadData,
	output logic                cpuBusy,
	// Arbiter side
	output logic                cpuReq,
	output lspcPkg::vramOp_t    cpuOp,
	output lspcPkg::vramAddr_t  cpuAddr,
	output lspcPkg::vramWord_t  cpuWdata,
	input  logic                cpuDone,
	input  lspcPkg::vramWord_t  cpuRdata
);

	lspcPkg::portState_t state;
	// Current VRAM address
	lspcPkg::vramAddr_t vramAddr;
	// Added to the address after each data write
	lspcPkg::vramAddr_t vramMod;
	// Word waiting to be stored
	lspcPkg::vramWord_t pendData;
	// Prefetched word at the current address
	lspcPkg::vramWord_t readData;
	logic accept;

	// Strobes during a sequence are dropped
	assign accept = cpuWrite & (state == lspcPkg::stIdle);

	// ==================================================
	// Register writes and access sequencing
	// ==================================================
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			state <= lspcPkg::stIdle;
			vramAddr <= '0;
			vramMod <= '0;
			pendData <= '0;
			readData <= '0;
		end
		else
		begin
			case (state)
				lspcPkg::stIdle:
				begin
					if (accept)
					begin
						case (cpuSel)
							lspcPkg::regVramAddr:
							begin
								// New address, then refill data register
								vramAddr <= cpuWriteData[lspcPkg::vramAddrWidth-1:0];
								state <= lspcPkg::stRead;
							end
							lspcPkg::regVramRw:
							begin
								pendData <= cpuWriteData;
								state <= lspcPkg::stWrite;
							end
							lspcPkg::regVramMod:
								vramMod <= cpuWriteData[lspcPkg::vramAddrWidth-1:0];
							default:
							begin
								// Index 3, nothing to do
							end
						endcase
					end
				end
				lspcPkg::stWrite:
				begin
					if (cpuDone)
					begin
						// Step by modulo, wraps at 4096 words
						vramAddr <= vramAddr + vramMod;
						state <= lspcPkg::stRead;
					end
				end
				lspcPkg::stRead:
				begin
					if (cpuDone)
					begin
						readData <= cpuRdata;
						state <= lspcPkg::stIdle;
					end
				end
				default:
					state <= lspcPkg::stIdle;
			endcase
		end
	end

	// Request lines follow the sequencer state
	assign cpuReq = (state != lspcPkg::stIdle);
	assign cpuBusy = (state != lspcPkg::stIdle);
	assign cpuOp = (state == lspcPkg::stWrite) ? lspcPkg::opWrite : lspcPkg::opRead;
	assign cpuAddr = vramAddr;
	assign cpuWdata = pendData;

	// Host read mux
	// Address and data indexes both give VRAM data
	always_comb
	begin
		case (cpuSel)
			lspcPkg::regVramAddr,
			lspcPkg::regVramRw:
				cpuReadData = readData;
			lspcPkg::regVramMod:
				cpuReadData = lspcPkg::vramWord_t'(vramMod);
			default:
				cpuReadData = '0;
		endcase
	end

endmodule

// ==== hw/fixFetch.sv ====
// Fix layer pixel and raster counters, one-column-ahead fix map fetch and tile output
module fixFetch #(
	parameter lspcPkg::vramAddr_t fixMapBase = 12'h800,
	parameter int pixelsPerLine = 384,
	parameter int linesPerFrame = 264,
	parameter int pixelDiv = 4
) (
	input  logic                CLK_24M,
	input  logic                T73A_OUT,
	output logic                fetchReq,
	output lspcPkg::vramAddr_t  fetchAddr,
	input  logic                fetchDone,
	input  lspcPkg::vramWord_t  fetchRdata,
	output logic                tileStrobe,
	output logic [11:0]         fixTile,
	output logic [3:0]          fixPal,
	output logic [5:0]          fixColumn,
	output logic [4:0]          fixRow,
	output logic [2:0]          fixLine
);

	localparam int divWidth = (pixelDiv > 1) ? $clog2(pixelDiv) : 1;
	localparam int pixWidth = $clog2(pixelsPerLine);
	localparam int rasterWidth = $clog2(linesPerFrame);
	localparam int colsPerLine = pixelsPerLine / 8;

	logic [divWidth-1:0] divCnt;
	logic [pixWidth-1:0] pixelCnt;
	logic [rasterWidth-1:0] rasterCnt;
	logic [rasterWidth-1:0] nextRaster;
	logic [5:0] nextCol;
	logic [4:0] nextRow;
	logic colStart;
	// Lookahead word and its valid flag
	lspcPkg::vramWord_t fetchWord;
	logic wordValid;

	// ==================================================
	// Pixel and raster counters
	// ==================================================
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			divCnt <= '0;
			pixelCnt <= '0;
			rasterCnt <= '0;
		end
		else if (divCnt == divWidth'(pixelDiv - 1))
		begin
			divCnt <= '0;
			if (pixelCnt == pixWidth'(pixelsPerLine - 1))
			begin
				pixelCnt <= '0;
				rasterCnt <= nextRaster;
			end
			else
				pixelCnt <= pixelCnt + 1'b1;
		end
		else
			divCnt <= divCnt + 1'b1;
	end

	assign nextRaster = (rasterCnt == rasterWidth'(linesPerFrame - 1)) ? '0 : rasterCnt + 1'b1;
	assign fixColumn = 6'(pixelCnt >> 3);
	assign fixRow = 5'(rasterCnt >> 3);
	assign fixLine = rasterCnt[2:0];

	// First clock of pixel 0 of a column
	assign colStart = (divCnt == '0) && (pixelCnt[2:0] == 3'd0);

	// Next column, wrapping to column 0 of the following line
	assign nextCol = (fixColumn == 6'(colsPerLine - 1)) ? 6'd0 : fixColumn + 6'd1;
	// Column 0 is shown on the next raster, take its row
	assign nextRow = (nextCol == 6'd0) ? 5'(nextRaster >> 3) : fixRow;

	// ==================================================
	// Fetch and present
	// ==================================================
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			fetchReq <= 1'b0;
			fetchAddr <= '0;
			fetchWord <= '0;
			wordValid <= 1'b0;
			tileStrobe <= 1'b0;
			fixTile <= '0;
			fixPal <= '0;
		end
		else
		begin
			tileStrobe <= colStart & wordValid;
			if (colStart)
			begin
				// Show the prefetched word, if any
				if (wordValid)
				begin
					fixPal <= fetchWord[15:12];
					fixTile <= fetchWord[11:0];
				end
				wordValid <= 1'b0;
				// Ask for the following column, 32 rows per map column
				fetchReq <= 1'b1;
				fetchAddr <= fixMapBase + lspcPkg::vramAddr_t'({nextCol, 5'd0})
					+ lspcPkg::vramAddr_t'(nextRow);
			end
			else if (fetchDone)
			begin
				fetchReq <= 1'b0;
				fetchWord <= fetchRdata;
				wordValid <= 1'b1;
			end
		end
	end

endmodule

// ==== hw/lspcPkg.sv ====
// VRAM widths, word and address types, bus operation, CPU register and port state enums
package lspcPkg;

	// ==================================================
	// Widths
	// ==================================================

	// One VRAM word, also the CPU data width
	localparam int wordWidth = 16;
	// 4096 words of VRAM
	localparam int vramAddrWidth = 12;

	// ==================================================
	// Word types
	// ==================================================

	typedef logic [wordWidth-1:0] vramWord_t;
	typedef logic [vramAddrWidth-1:0] vramAddr_t;

	// ==================================================
	// Enums
	// ==================================================

	// CPU request type towards the arbiter
	typedef enum logic
	{
		opRead  = 1'b0,
		opWrite = 1'b1
	} vramOp_t;

	// CPU register index, value 3 is unused
	typedef enum logic [1:0]
	{
		regVramAddr = 2'd0,
		regVramRw   = 2'd1,
		regVramMod  = 2'd2
	} regSel_t;

	// CPU port sequencer
	// Write issues the store, read refills the data register
	typedef enum logic [1:0]
	{
		stIdle  = 2'd0,
		stWrite = 2'd1,
		stRead  = 2'd2
	} portState_t;

endpackage

// ==== hw/lspcVideoTop.sv ====
// Video top level with CPU VRAM port, fix fetch engine, VRAM arbiter and VRAM
module lspcVideoTop #(
	parameter lspcPkg::vramAddr_t fixMapBase = 12'h800,
	parameter int pixelsPerLine = 384,
	parameter int linesPerFrame = 264,
	parameter int pixelDiv = 4
) (
	input  logic                CLK_24M,
	input  logic                T73A_OUT,
	// Host register port
	input  lspcPkg::regSel_t    cpuSel,
	input  lspcPkg::vramWord_t  cpuWriteData,
	input  logic                cpuWrite,
	output lspcPkg::vramWord_t  cpuReadData,
	output logic                cpuBusy,
	// Fix layer output
	output logic                tileStrobe,
	output logic [11:0]         fixTile,
	output logic [3:0]          fixPal,
	output logic [5:0]          fixColumn,
	output logic [4:0]          fixRow,
	output logic [2:0]          fixLine
);

	// CPU request channel
	logic cpuReq;
	lspcPkg::vramOp_t cpuOp;
	lspcPkg::vramAddr_t cpuAddr;
	lspcPkg::vramWord_t cpuWdata;
	logic cpuDone;
	lspcPkg::vramWord_t cpuRdata;

	// Fetch request channel
	logic fetchReq;
	lspcPkg::vramAddr_t fetchAddr;
	logic fetchDone;
	lspcPkg::vramWord_t fetchRdata;

	// Memory port
	logic memEn;
	logic memWe;
	lspcPkg::vramAddr_t memAddr;
	lspcPkg::vramWord_t memWdata;
	lspcPkg::vramWord_t memRdata;

	// ==================================================
	// Instances
	// ==================================================
	cpuVramPort cpuVramPort_inst (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT),
		.cpuSel(cpuSel), .cpuWriteData(cpuWriteData), .cpuWrite(cpuWrite),
		.cpuReadData(cpuReadData), .cpuBusy(cpuBusy),
		.cpuReq(cpuReq), .cpuOp(cpuOp), .cpuAddr(cpuAddr), .cpuWdata(cpuWdata),
		.cpuDone(cpuDone), .cpuRdata(cpuRdata)
	);

	fixFetch #(
		.fixMapBase(fixMapBase), .pixelsPerLine(pixelsPerLine),
		.linesPerFrame(linesPerFrame), .pixelDiv(pixelDiv)
	) fixFetch_inst (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT),
		.fetchReq(fetchReq), .fetchAddr(fetchAddr),
		.fetchDone(fetchDone), .fetchRdata(fetchRdata),
		.tileStrobe(tileStrobe), .fixTile(fixTile), .fixPal(fixPal),
		.fixColumn(fixColumn), .fixRow(fixRow), .fixLine(fixLine)
	);

	// Fetch has priority over the CPU
	vramArbiter vramArbiter_inst (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT),
		.fetchReq(fetchReq), .fetchAddr(fetchAddr),
		.fetchDone(fetchDone), .fetchRdata(fetchRdata),
		.cpuReq(cpuReq), .cpuOp(cpuOp), .cpuAddr(cpuAddr), .cpuWdata(cpuWdata),
		.cpuDone(cpuDone), .cpuRdata(cpuRdata),
		.memEn(memEn), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata),
		.memRdata(memRdata)
	);

	vramBank vramBank_inst (
		.CLK_24M(CLK_24M),
		.memEn(memEn), .memWe(memWe), .memAddr(memAddr),
		.memWdata(memWdata), .memRdata(memRdata)
	);

endmodule

// ==== hw/vramArbiter.sv ====
// VRAM arbiter with fetch priority, one-cycle grant and done pulse to the owner
module vramArbiter (
	input  logic                CLK_24M,
	input  logic                T73A_OUT,
	// Fix fetch side
	input  logic                fetchReq,
	input  lspcPkg::vramAddr_t  fetchAddr,
	output logic                fetchDone,
	output lspcPkg::vramWord_t  fetchRdata,
	// CPU port side
	input  logic                cpuReq,
	input  lspcPkg::vramOp_t    cpuOp,
	input  lspcPkg::vramAddr_t  cpuAddr,
	input  lspcPkg::vramWord_t  cpuWdata,
	output logic                cpuDone,
	output lspcPkg::vramWord_t  cpuRdata,
	// Memory port
	output logic                memEn,
	output logic                memWe,
	output lspcPkg::vramAddr_t  memAddr,
	output lspcPkg::vramWord_t  memWdata,
	input  lspcPkg::vramWord_t  memRdata
);

	// Grant cycle in progress
	logic busy;
	// Owner of the last grant, 1 for fetch
	logic ownerFetch;
	// Cycle after the grant, read data valid
	logic doneValid;
	logic fetchPend;
	logic cpuPend;

	// Requester being completed still holds req this cycle
	// so its request is masked to avoid a second grant
	assign fetchPend = fetchReq & ~(doneValid & ownerFetch);
	assign cpuPend = cpuReq & ~(doneValid & ~ownerFetch);

	// ==================================================
	// Grant sequencing
	// ==================================================
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			busy <= 1'b0;
			ownerFetch <= 1'b0;
			doneValid <= 1'b0;
		end
		else
		begin
			doneValid <= busy;
			if (busy)
				busy <= 1'b0;
			else if (fetchPend)
			begin
				// Video first
				busy <= 1'b1;
				ownerFetch <= 1'b1;
			end
			else if (cpuPend)
			begin
				busy <= 1'b1;
				ownerFetch <= 1'b0;
			end
		end
	end

	// Requests are held until done, so the port muxes straight from them
	assign memEn = busy;
	assign memWe = busy & ~ownerFetch & (cpuOp == lspcPkg::opWrite);
	assign memAddr = ownerFetch ? fetchAddr : cpuAddr;
	// Only the CPU ever writes
	assign memWdata = cpuWdata;

	// Done pulses one cycle after the grant
	assign fetchDone = doneValid & ownerFetch;
	assign cpuDone = doneValid & ~ownerFetch;
	assign fetchRdata = memRdata;
	assign cpuRdata = memRdata;

endmodule

// ==== hw/vramBank.sv ====
// Single-port synchronous VRAM, 4096 words, one-clock read latency
module vramBank (
	input  logic                CLK_24M,
	input  logic                memEn,
	input  logic                memWe,
	input  lspcPkg::vramAddr_t  memAddr,
	input  lspcPkg::vramWord_t  memWdata,
	output lspcPkg::vramWord_t  memRdata
);

	localparam int depth = 1 << lspcPkg::vramAddrWidth;

	// Storage, contents undefined until written
	lspcPkg::vramWord_t mem [0:depth-1];

	// One access per enabled cycle
	// Writes do not disturb the read register
	always_ff @(posedge CLK_24M)
	begin
		if (memEn)
		begin
			if (memWe)
				mem[memAddr] <= memWdata;
			else
				memRdata <= mem[memAddr];
		end
	end

endmodule

// ==== lspcVideo.f ====
hw/lspcPkg.sv
hw/vramBank.sv
hw/vramArbiter.sv
hw/cpuVramPort.sv
hw/fixFetch.sv
hw/lspcVideoTop.sv
verif/lspcVideoTb.sv

// ==== verif/lspcVideoTb.sv ====
// Testbench for the video top level with host tasks, VRAM reference model, fix checks and watchdog
module lspcVideoTb;

	localparam lspcPkg::vramAddr_t fixMapBase = 12'h800;
	localparam int pixelsPerLine = 384;
	localparam int linesPerFrame = 264;
	localparam int pixelDiv = 4;
	localparam int colsPerLine = pixelsPerLine / 8;
	localparam int strobesPerFrame = colsPerLine * linesPerFrame;
	// Two frames plus room for the CPU traffic
	localparam int watchdogCycles = pixelsPerLine * linesPerFrame * pixelDiv * 2 + 20000;

	logic CLK_24M;
	logic T73A_OUT;
	lspcPkg::regSel_t cpuSel;
	lspcPkg::vramWord_t cpuWriteData;
	logic cpuWrite;
	lspcPkg::vramWord_t cpuReadData;
	logic cpuBusy;
	logic tileStrobe;
	logic [11:0] fixTile;
	logic [3:0] fixPal;
	logic [5:0] fixColumn;
	logic [4:0] fixRow;
	logic [2:0] fixLine;

	// Reference VRAM and a flag per word set once written
	lspcPkg::vramWord_t vramModel [0:4095];
	logic modelValid [0:4095];

	// Fix monitor state
	logic checkFix;
	int strobeCount;
	int fixChecks;
	int expIndex;
	int expCol;
	int expRaster;
	lspcPkg::vramAddr_t fixAddr;

	lspcVideoTop #(
		.fixMapBase(fixMapBase), .pixelsPerLine(pixelsPerLine),
		.linesPerFrame(linesPerFrame), .pixelDiv(pixelDiv)
	) lspcVideoTop_inst (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT),
		.cpuSel(cpuSel), .cpuWriteData(cpuWriteData), .cpuWrite(cpuWrite),
		.cpuReadData(cpuReadData), .cpuBusy(cpuBusy),
		.tileStrobe(tileStrobe), .fixTile(fixTile), .fixPal(fixPal),
		.fixColumn(fixColumn), .fixRow(fixRow), .fixLine(fixLine)
	);

	initial
	begin
		CLK_24M = 1'b0;
		forever
			#10 CLK_24M = ~CLK_24M;
	end

	// ==================================================
	// Failure reporting and host tasks
	// ==================================================
	task automatic reportMismatch(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Mismatch in %s: expected %h, actual %h", testName, expected, actual);
		$display("Simulation FAILED");
		$fatal(1, "value check failed");
	endtask

	task automatic reportFailure(input string what);
		$display("Error: %s", what);
		$display("Simulation FAILED");
		$fatal(1, "check failed");
	endtask

	// Returns on a falling edge with the port idle
	task automatic waitIdle();
		@(negedge CLK_24M);
		while (cpuBusy)
			@(negedge CLK_24M);
	endtask

	// Strobe only once the port is idle
	task automatic hostWrite(input lspcPkg::regSel_t sel, input lspcPkg::vramWord_t data);
		waitIdle();
		cpuSel = sel;
		cpuWriteData = data;
		cpuWrite = 1'b1;
		@(negedge CLK_24M);
		cpuWrite = 1'b0;
	endtask

	task automatic hostRead(input lspcPkg::regSel_t sel, output lspcPkg::vramWord_t data);
		waitIdle();
		cpuSel = sel;
		@(negedge CLK_24M);
		data = cpuReadData;
	endtask

	task automatic modelWrite(input lspcPkg::vramAddr_t addr, input lspcPkg::vramWord_t data);
		vramModel[addr] = data;
		modelValid[addr] = 1'b1;
	endtask

	// Random modulo and a start near the top so every run wraps past 4095
	// Span stays clear of the fix map
	task automatic modSequence(input int count);
		lspcPkg::vramAddr_t startAddr;
		lspcPkg::vramAddr_t modVal;
		lspcPkg::vramAddr_t addr;
		lspcPkg::vramWord_t word;
		lspcPkg::vramWord_t got;
		int pass;
		int k;
		startAddr = 12'hF00 + lspcPkg::vramAddr_t'($urandom % 128);
		modVal = lspcPkg::vramAddr_t'(18 + $urandom % 14);
		hostWrite(lspcPkg::regVramMod, 16'(modVal));
		// Second pass overwrites, so its prefetches hit known words
		for (pass = 0; pass < 2; pass++)
		begin
			hostWrite(lspcPkg::regVramAddr, 16'(startAddr));
			addr = startAddr;
			for (k = 0; k < count; k++)
			begin
				word = 16'($urandom);
				hostWrite(lspcPkg::regVramRw, word);
				modelWrite(addr, word);
				addr = addr + modVal;
				hostRead(lspcPkg::regVramAddr, got);
				if (modelValid[addr])
					assert (got === vramModel[addr])
					else reportMismatch("prefetch", vramModel[addr], got);
			end
		end
		// Read back through address writes
		for (k = 0; k < count; k++)
		begin
			addr = lspcPkg::vramAddr_t'(startAddr + k * modVal);
			hostWrite(lspcPkg::regVramAddr, 16'(addr));
			hostRead(lspcPkg::regVramRw, got);
			assert (got === vramModel[addr])
			else reportMismatch("modulo readback", vramModel[addr], got);
		end
	endtask

	// Column-major map with 32 rows per column
	task automatic fillFixMap();
		int i;
		lspcPkg::vramWord_t word;
		hostWrite(lspcPkg::regVramMod, 16'd1);
		hostWrite(lspcPkg::regVramAddr, 16'(fixMapBase));
		for (i = 0; i < colsPerLine * 32; i++)
		begin
			word = 16'($urandom);
			hostWrite(lspcPkg::regVramRw, word);
			modelWrite(lspcPkg::vramAddr_t'(fixMapBase + i), word);
		end
		waitIdle();
	endtask

	// ==================================================
	// Fix output monitor
	// ==================================================
	// First boundary after reset has no word, so strobe n shows boundary n+1
	always @(negedge CLK_24M)
	begin
		if (T73A_OUT && tileStrobe)
		begin
			expIndex = strobeCount + 1;
			expCol = expIndex % colsPerLine;
			expRaster = (expIndex / colsPerLine) % linesPerFrame;
			assert (fixColumn == 6'(expCol))
			else reportMismatch("fix column", expCol, fixColumn);
			assert (fixLine == 3'(expRaster))
			else reportMismatch("fix line", expRaster % 8, fixLine);
			assert (fixRow == 5'(expRaster / 8))
			else reportMismatch("fix row", (expRaster / 8) % 32, fixRow);
			if (checkFix)
			begin
				fixAddr = lspcPkg::vramAddr_t'(fixMapBase + expCol * 32
					+ (expRaster / 8) % 32);
				assert ({fixPal, fixTile} === vramModel[fixAddr])
				else reportMismatch("fix tile", vramModel[fixAddr], {fixPal, fixTile});
				fixChecks++;
			end
			strobeCount++;
		end
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge CLK_24M);
		$display("Error: watchdog expired after %0d cycles, run did not finish", watchdogCycles);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	// ==================================================
	// Main sequence
	// ==================================================
	initial
	begin
		lspcPkg::vramAddr_t addrA;
		lspcPkg::vramWord_t dataD;
		lspcPkg::vramWord_t got;
		int startCount;
		int seq;
		addrA = lspcPkg::vramAddr_t'($urandom(32'h9c266080));
		T73A_OUT = 1'b0;
		cpuSel = lspcPkg::regVramAddr;
		cpuWriteData = '0;
		cpuWrite = 1'b0;
		checkFix = 1'b0;
		strobeCount = 0;
		fixChecks = 0;
		for (int i = 0; i < 4096; i++)
			modelValid[i] = 1'b0;
		repeat (5) @(posedge CLK_24M);
		@(negedge CLK_24M);
		T73A_OUT = 1'b1;

		// Reset state
		@(negedge CLK_24M);
		assert (cpuBusy === 1'b0) else reportFailure("cpuBusy is not low after reset");
		hostRead(lspcPkg::regVramMod, got);
		assert (got === 16'h0000) else reportMismatch("reset modulo", 16'h0000, got);

		// Single write and read-back below the fix map
		addrA = 12'h100 + lspcPkg::vramAddr_t'($urandom % 256);
		dataD = 16'($urandom);
		hostWrite(lspcPkg::regVramMod, 16'd1);
		hostWrite(lspcPkg::regVramAddr, 16'(addrA));
		hostWrite(lspcPkg::regVramRw, dataD);
		modelWrite(addrA, dataD);
		hostWrite(lspcPkg::regVramAddr, 16'(addrA));
		waitIdle();
		hostRead(lspcPkg::regVramRw, got);
		assert (got === dataD) else reportMismatch("write readback", dataD, got);

		// Fill the map and skip strobes whose fetch may predate the last write
		fillFixMap();
		startCount = strobeCount + 2;
		while (strobeCount < startCount)
			@(negedge CLK_24M);
		checkFix = 1'b1;

		// CPU traffic against fetch priority during one frame
		for (seq = 0; seq < 4; seq++)
			modSequence(16);
		while (strobeCount < startCount + strobesPerFrame)
			@(negedge CLK_24M);
		checkFix = 1'b0;
		assert (fixChecks > 0) else reportFailure("no tile strobe was checked");

		$display("Simulation PASSED");
		$finish;
	end

endmodule
